/* mem_access.f */
hdl/core_pkg.sv
hdl/mem_pkg.sv
hdl/mem_misaligned.sv
hdl/store_aligner.sv
hdl/data_ram.sv
hdl/load_aligner.sv
hdl/mem_access_unit.sv
dv/clk_gen.sv
dv/mem_access_tb.sv

/* Makefile */
# Verilator build and run of the memory access unit testbench.
# Any variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= mem_access_tb
FILELIST  ?= mem_access.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Finished with no errors

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail.
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mem_access_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_tb;

  localparam int unsigned clk_period = 40;
  localparam int unsigned rst_cycles = 10;
  // Words under test, all filled before the first load.
  localparam int unsigned test_words = 64;
  localparam int unsigned ref_aw     = $clog2(test_words * 8);
  localparam int unsigned per_size   = 8;
  localparam int unsigned n_random   = 200;
  // Cycles of the whole run. A single access takes two.
  localparam int unsigned run_cycles = rst_cycles + 3
                                     + test_words + 2      // fill burst
                                     + 4 * per_size * 4    // store and readback
                                     + 2 * 31 * 2          // store and 30 loads, two words
                                     + 49 * 3 * 2          // misaligned triples
                                     + 10 * 2              // fetches
                                     + n_random + 2;
  localparam int unsigned timeout_ns = (run_cycles + 100) * clk_period;

  logic                       clk;
  logic                       rst_n;
  core_pkg::mem_req_t         req;
  logic                       ack;
  logic                       misaligned;
  logic [63:0]                rdata;
  // Byte-wide reference of the words under test.
  logic [7:0]                 ref_mem [test_words * 8];
  // Requests issued back to back.
  core_pkg::mem_req_t         burst_q [$];
  int unsigned                errors = 0;

  clk_gen #(.period_ns(clk_period), .rst_cycles(rst_cycles)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_access_unit dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .ack_o        (ack),
    .misaligned_o (misaligned),
    .rdata_o      (rdata)
  );

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic core_pkg::mem_req_t make_req(input core_pkg::kind_e kind,
      input logic [2:0] size, input logic is_unsigned, input logic [63:0] addr,
      input logic [63:0] wdata);
    core_pkg::mem_req_t r;
    r.req         = 1'b1;
    r.kind        = kind;
    r.size        = core_pkg::size_e'(size);
    r.is_unsigned = is_unsigned;
    r.addr        = addr;
    r.wdata       = wdata;
    return r;
  endfunction

  function automatic string describe(input core_pkg::mem_req_t r);
    return $sformatf("kind %0d size %0d unsigned %0d addr %h", r.kind, r.size,
                     r.is_unsigned, r.addr);
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  // Random byte address inside the words under test, aligned to nbytes.
  function automatic logic [63:0] rand_addr(input int unsigned nbytes);
    int unsigned a;
    a = $urandom_range(test_words * 8 - 1, 0);
    a = a & ~(nbytes - 1);
    return 64'(a);
  endfunction

  // Natural alignment for loads and stores.
  // Fetches need halfwords with compressed code.
  function automatic logic permitted(input core_pkg::mem_req_t r);
    logic [2:0] mask;
    if (r.kind == core_pkg::kind_fetch) begin
      mask = core_pkg::has_rvc ? 3'b001 : 3'b011;
      return (r.addr[2:0] & mask) == 3'b000;
    end
    if (r.size > 3'd3) begin
      return 1'b0;
    end
    mask = 3'((1 << r.size) - 1);
    return (r.addr[2:0] & mask) == 3'b000;
  endfunction

  function automatic logic [63:0] predict_rdata(input core_pkg::mem_req_t r);
    logic [63:0]       val;
    logic [ref_aw-1:0] idx;
    int unsigned       base;
    int unsigned       nbytes;
    val    = '0;
    base   = r.addr[31:0];
    nbytes = 1 << r.size;
    if (!permitted(r) || r.kind == core_pkg::kind_store) begin
      return '0;
    end
    if (r.kind == core_pkg::kind_fetch) begin
      // Four bytes, zeros past the end of the word.
      for (int i = 3; i >= 0; i--) begin
        idx = ref_aw'(base + i);
        val = {val[55:0], ((base % 8) + i < 8) ? ref_mem[idx] : 8'h00};
      end
      return val;
    end
    // Most significant byte shifted in first.
    for (int i = nbytes - 1; i >= 0; i--) begin
      idx = ref_aw'(base + i);
      val = {val[55:0], ref_mem[idx]};
    end
    if (!r.is_unsigned && ((val >> (8 * nbytes - 1)) & 64'd1) == 64'd1) begin
      val = val | ~((64'd1 << (8 * nbytes)) - 64'd1);
    end
    return val;
  endfunction

  // Only permitted stores change the reference.
  task automatic update_ref(input core_pkg::mem_req_t r);
    logic [ref_aw-1:0] idx;
    int unsigned       base;
    int unsigned       nbytes;
    base   = r.addr[31:0];
    nbytes = 1 << r.size;
    if (r.kind == core_pkg::kind_store && permitted(r)) begin
      for (int i = 0; i < nbytes; i++) begin
        idx          = ref_aw'(base + i);
        ref_mem[idx] = 8'(r.wdata >> (8 * i));
      end
    end
  endtask

  task automatic drive_req(input core_pkg::mem_req_t r);
    @(posedge clk);
    req <= r;
  endtask

  // Sampled at the falling edge, away from the registers.
  task automatic check_response(input logic exp_ack, input logic exp_mis,
                                input logic [63:0] exp_data, input string what);
    @(negedge clk);
    assert (ack === exp_ack)
      else report_error($sformatf("FAILED ack_o for %s: expected %h, got %h",
                                  what, exp_ack, ack));
    assert (misaligned === exp_mis)
      else report_error($sformatf("FAILED misaligned_o for %s: expected %h, got %h",
                                  what, exp_mis, misaligned));
    assert (rdata === exp_data)
      else report_error($sformatf("FAILED rdata_o for %s: expected %h, got %h",
                                  what, exp_data, rdata));
  endtask

  task automatic access_expect(input core_pkg::mem_req_t r, input logic mis,
                               input logic [63:0] data);
    drive_req(r);
    drive_req('0);
    check_response(1'b1, mis, data, describe(r));
  endtask

  task automatic single_access(input core_pkg::mem_req_t r);
    logic        mis;
    logic [63:0] data;
    mis  = ~permitted(r);
    data = predict_rdata(r);
    update_ref(r);
    access_expect(r, mis, data);
  endtask

  task automatic run_burst();
    logic        mis_q  [$];
    logic [63:0] data_q [$];
    foreach (burst_q[i]) begin
      mis_q.push_back(~permitted(burst_q[i]));
      data_q.push_back(predict_rdata(burst_q[i]));
      update_ref(burst_q[i]);
    end
    // Each response is due at the edge that presents the next request.
    drive_req(burst_q[0]);
    for (int i = 1; i <= burst_q.size(); i++) begin
      if (i < burst_q.size()) begin
        drive_req(burst_q[i]);
      end else begin
        drive_req('0);
      end
      check_response(1'b1, mis_q[i-1], data_q[i-1], describe(burst_q[i-1]));
    end
    drive_req('0);
    check_response(1'b0, 1'b0, '0, "idle cycle after burst");
    burst_q.delete();
  endtask

  // A misaligned load held during reset must leave every output at zero.
  task automatic reset_values();
    drive_req(make_req(core_pkg::kind_load, core_pkg::size_word, 1'b0, 64'h1, '0));
    repeat (rst_cycles - 3) check_response(1'b0, 1'b0, '0, "reset");
    drive_req('0);
    wait (rst_n === 1'b1);
    repeat (2) check_response(1'b0, 1'b0, '0, "idle after reset");
  endtask

  task automatic fill_memory();
    logic [63:0] a;
    for (int w = 0; w < test_words; w++) begin
      a = 64'(w * 8);
      burst_q.push_back(make_req(core_pkg::kind_store, core_pkg::size_dword, 1'b0, a,
                                 {a[31:0] ^ 32'hc3a5_0f1e, ~a[31:0]}));
    end
    run_burst();
  endtask

  // Dword readback shows neighbours of the strobes unchanged.
  task automatic store_sizes();
    logic [63:0] a;
    for (int s = 0; s < 4; s++) begin
      for (int n = 0; n < per_size; n++) begin
        a = rand_addr(1 << s);
        single_access(make_req(core_pkg::kind_store, 3'(s), 1'b0, a, rand64()));
        single_access(make_req(core_pkg::kind_load, core_pkg::size_dword, 1'b0,
                               {a[63:3], 3'b000}, '0));
      end
    end
  endtask

  task automatic load_extension();
    logic [63:0] a;
    for (int w = 0; w < 2; w++) begin
      a = rand_addr(8);
      // Fixed pattern has both signs in every lane size.
      single_access(make_req(core_pkg::kind_store, core_pkg::size_dword, 1'b0, a,
                             (w == 0) ? 64'h8f7e_6d5c_4b3a_2918 : rand64()));
      for (int s = 0; s < 4; s++) begin
        for (int off = 0; off < 8; off += (1 << s)) begin
          for (int u = 0; u < 2; u++) begin
            single_access(make_req(core_pkg::kind_load, 3'(s), 1'(u), a + 64'(off), '0));
          end
        end
      end
    end
  endtask

  // Store, readback of the word, then the load itself.
  task automatic misaligned_accesses();
    logic [63:0] base;
    logic [63:0] a;
    base = rand_addr(8);
    for (int s = 1; s < 8; s++) begin
      for (int off = 0; off < 8; off++) begin
        a = base + 64'(off);
        if (s < 4 && (off % (1 << s)) == 0) begin
          continue;
        end
        single_access(make_req(core_pkg::kind_store, 3'(s), 1'b0, a, rand64()));
        single_access(make_req(core_pkg::kind_load, core_pkg::size_dword, 1'b0, base, '0));
        single_access(make_req(core_pkg::kind_load, 3'(s), 1'b0, a, '0));
      end
    end
  endtask

  task automatic fetch_alignment();
    logic [63:0] a;
    a = rand_addr(8);
    single_access(make_req(core_pkg::kind_store, core_pkg::size_dword, 1'b0, a,
                           64'h1122_3344_5566_7788));
    for (int off = 0; off < 8; off++) begin
      single_access(make_req(core_pkg::kind_fetch, 3'd0, 1'b0, a + 64'(off), '0));
    end
    // Offset 6 gives bytes 6 and 7, then zeros.
    access_expect(make_req(core_pkg::kind_fetch, 3'd0, 1'b0, a + 64'd6, '0),
                  !core_pkg::has_rvc, core_pkg::has_rvc ? 64'h1122 : 64'h0);
  endtask

  task automatic random_burst();
    logic [63:0] a;
    logic [2:0]  s;
    for (int g = 0; g < n_random / 8; g++) begin
      // Store, then a load of the same word in the next cycle.
      s = 3'($urandom_range(3, 0));
      a = rand_addr(1 << s);
      burst_q.push_back(make_req(core_pkg::kind_store, s, 1'b0, a, rand64()));
      burst_q.push_back(make_req(core_pkg::kind_load, core_pkg::size_dword, 1'b0,
                                 {a[63:3], 3'b000}, '0));
      for (int i = 0; i < 6; i++) begin
        s = 3'($urandom_range(3, 0));
        // Now and then an illegal size code.
        if ($urandom_range(15, 0) == 0) begin
          s = 3'($urandom_range(7, 4));
        end
        a = rand_addr(($urandom_range(1, 0) == 1) ? 8 : 1);
        burst_q.push_back(make_req(core_pkg::kind_e'(2'($urandom_range(2, 0))), s,
                                   1'($urandom_range(1, 0)), a, rand64()));
      end
    end
    run_burst();
  endtask

  initial begin
    #(timeout_ns);
    report_error("Watchdog expired before the tests completed.");
  end

  initial begin
    void'($urandom(32'hfda5));
    req <= '0;
    reset_values();
    fill_memory();
    store_sizes();
    load_extension();
    misaligned_accesses();
    fetch_alignment();
    random_burst();
    @(posedge clk);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int unsigned period_ns  = 40,
  parameter int unsigned rst_cycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, low at time zero.
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Reset held for a number of cycles, released on a rising edge.
  initial begin
    rst_n_o <= 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/mem_access_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  core_pkg::mem_req_t          req_i,
  output logic                        ack_o,
  output logic                        misaligned_o,
  output logic [core_pkg::xlen-1:0]   rdata_o
);

  // Alignment permit for the current request.
  logic                         permit;
  // Gated RAM port.
  mem_pkg::ram_port_t           ram_port;
  // Read word, valid one cycle after the request.
  logic [core_pkg::xlen-1:0]    ram_rdata;

  // Alignment check.
  mem_misaligned u_misaligned (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .permit_o     (permit),
    .misaligned_o (misaligned_o)
  );

  // Strobes and lane-shifted store data.
  store_aligner u_store_aligner (
    .req_i    (req_i),
    .permit_i (permit),
    .ram_o    (ram_port)
  );

  // Data RAM.
  data_ram u_data_ram (
    .clk_i   (clk_i),
    .ram_i   (ram_port),
    .rdata_o (ram_rdata)
  );

  // Response path.
  // The flag arrives in the same cycle as the read word.
  load_aligner u_load_aligner (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .rdata_i      (ram_rdata),
    .misaligned_i (misaligned_o),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o)
  );

endmodule

`default_nettype wire

/* hdl/load_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module load_aligner (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  core_pkg::mem_req_t          req_i,
  input  wire [core_pkg::xlen-1:0]    rdata_i,
  input  wire                         misaligned_i,
  output logic                        ack_o,
  output logic [core_pkg::xlen-1:0]   rdata_o
);

  // Request info held for the response cycle.
  logic               ack_q;
  core_pkg::kind_e    kind_q;
  core_pkg::size_e    size_q;
  logic               unsigned_q;
  logic [2:0]         off_q;

  // RAM word as lanes.
  mem_pkg::lane_view_u        rd;
  logic [7:0]                 sel_b;
  logic [15:0]                sel_h;
  logic [31:0]                sel_w;
  logic [31:0]                fetch_w;
  logic [core_pkg::xlen-1:0]  result;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q      <= 1'b0;
      kind_q     <= core_pkg::kind_load;
      size_q     <= core_pkg::size_byte;
      unsigned_q <= 1'b0;
      off_q      <= '0;
    end else begin
      ack_q      <= req_i.req;
      kind_q     <= req_i.kind;
      size_q     <= req_i.size;
      unsigned_q <= req_i.is_unsigned;
      off_q      <= req_i.addr[2:0];
    end
  end

  assign rd = rdata_i;

  // Lane select at the registered offset.
  assign sel_b = rd.b[off_q];
  assign sel_h = rd.h[off_q[2:1]];
  assign sel_w = {rd.h[{off_q[2], 1'b1}], rd.h[{off_q[2], 1'b0}]};

  // Fetch takes four bytes from the offset.
  // Bytes past the word end read as zero.
  always_comb begin
    logic [3:0] idx;
    fetch_w = '0;
    for (int i = 0; i < 4; i++) begin
      idx = {1'b0, off_q} + 4'(i);
      fetch_w[8*i +: 8] = idx[3] ? 8'h00 : rd.b[idx[2:0]];
    end
  end

  // Extension by size, sign only for signed loads.
  always_comb begin
    result = '0;
    case (kind_q)
      core_pkg::kind_load: begin
        case (size_q)
          core_pkg::size_byte:
            result = {{(core_pkg::xlen-8){sel_b[7] & ~unsigned_q}}, sel_b};
          core_pkg::size_hword:
            result = {{(core_pkg::xlen-16){sel_h[15] & ~unsigned_q}}, sel_h};
          core_pkg::size_word:
            result = {{(core_pkg::xlen-32){sel_w[31] & ~unsigned_q}}, sel_w};
          core_pkg::size_dword:
            result = rdata_i;
          default:
            result = '0;
        endcase
      end
      core_pkg::kind_fetch: result = {{(core_pkg::xlen-32){1'b0}}, fetch_w};
      // Stores return nothing.
      default:              result = '0;
    endcase
  end

  // Flagged accesses and idle cycles return zero.
  assign rdata_o = (ack_q && !misaligned_i) ? result : '0;
  assign ack_o   = ack_q;

endmodule

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire                         clk_i,
  input  mem_pkg::ram_port_t          ram_i,
  output logic [core_pkg::xlen-1:0]   rdata_o
);

  // Word array.
  logic [core_pkg::xlen-1:0] mem [mem_pkg::ram_words];

  // Byte lane writes.
  // Only the lanes with a strobe change.
  always_ff @(posedge clk_i) begin
    if (ram_i.we) begin
      for (int i = 0; i < mem_pkg::strb_w; i++) begin
        if (ram_i.strb[i]) begin
          mem[ram_i.waddr][8*i +: 8] <= ram_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Synchronous read.
  // Same-word write in the same cycle returns the old word.
  // Output holds while idle.
  always_ff @(posedge clk_i) begin
    if (ram_i.en) begin
      rdata_o <= mem[ram_i.waddr];
    end
  end

endmodule

`default_nettype wire

/* hdl/store_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module store_aligner (
  input  core_pkg::mem_req_t    req_i,
  input  wire                   permit_i,
  output mem_pkg::ram_port_t    ram_o
);

  // Byte offset inside the RAM word.
  logic [2:0]                 off;
  // Strobes before write gating.
  logic [mem_pkg::strb_w-1:0] strb_raw;
  // Store data copied into every lane of its size.
  mem_pkg::lane_view_u        lanes;
  logic                       en;
  logic                       we;

  assign off = req_i.addr[2:0];

  // Any permitted request uses the RAM.
  assign en = req_i.req & permit_i;
  assign we = en & (req_i.kind == core_pkg::kind_store);

  // Strobes and lane copies by size.
  always_comb begin
    lanes.b  = req_i.wdata;
    strb_raw = '0;
    case (req_i.size)
      core_pkg::size_byte: begin
        strb_raw = 8'h01 << off;
        for (int i = 0; i < mem_pkg::strb_w; i++) begin
          lanes.b[i] = req_i.wdata[7:0];
        end
      end
      core_pkg::size_hword: begin
        strb_raw = 8'h03 << off;
        for (int i = 0; i < mem_pkg::strb_w / 2; i++) begin
          lanes.h[i] = req_i.wdata[15:0];
        end
      end
      core_pkg::size_word: begin
        strb_raw = 8'h0f << off;
        // Low half into even halfwords, high half into odd ones.
        for (int i = 0; i < mem_pkg::strb_w / 4; i++) begin
          lanes.h[2*i]   = req_i.wdata[15:0];
          lanes.h[2*i+1] = req_i.wdata[31:16];
        end
      end
      core_pkg::size_dword: strb_raw = 8'hff;
      default:              strb_raw = '0;
    endcase
    // Each strobed lane holds the store byte at its place within the access.
    for (int i = 0; i < mem_pkg::strb_w; i++) begin
      if (strb_raw[i]) begin
        a_lane_data: assert (lanes.b[i] == req_i.wdata[8 * (i % (1 << req_i.size)) +: 8]);
      end
    end
  end

  assign ram_o.en    = en;
  assign ram_o.we    = we;
  assign ram_o.waddr = req_i.addr[mem_pkg::ram_aw+2:3];
  assign ram_o.strb  = we ? strb_raw : '0;
  assign ram_o.wdata = lanes;

endmodule

`default_nettype wire

/* hdl/mem_misaligned.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_misaligned (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  core_pkg::mem_req_t  req_i,
  output logic                permit_o,
  output logic                misaligned_o
);

  // Alignment decode from kind, size and low address bits.
  always_comb begin
    if (req_i.kind == core_pkg::kind_fetch) begin
      // Fetch alignment depends only on the compressed extension.
      if (core_pkg::has_rvc) begin
        permit_o = ~req_i.addr[0];
      end else begin
        permit_o = ~|req_i.addr[1:0];
      end
    end else begin
      case (req_i.size)
        core_pkg::size_byte:  permit_o = 1'b1;
        core_pkg::size_hword: permit_o = ~req_i.addr[0];
        core_pkg::size_word:  permit_o = ~|req_i.addr[1:0];
        core_pkg::size_dword: permit_o = ~|req_i.addr[2:0];
        // Illegal size code.
        default:              permit_o = 1'b0;
      endcase
    end
  end

  // Flag reported with the response, one cycle later.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      misaligned_o <= 1'b0;
    end else begin
      misaligned_o <= req_i.req & ~permit_o;
    end
  end

  // Legal load or store flagged exactly when the address is no multiple of its width.
  a_flag_by_modulo: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (req_i.req && req_i.kind != core_pkg::kind_fetch
     && req_i.size <= core_pkg::size_dword)
    |=> misaligned_o
        == (($past(req_i.addr[2:0]) % (4'd1 << $past(req_i.size))) != 4'd0)
  );

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // RAM depth in 64-bit words.
  localparam int unsigned ram_words = 256;

  // Word address width.
  localparam int unsigned ram_aw = $clog2(ram_words);

  // One strobe per byte lane.
  localparam int unsigned strb_w = core_pkg::xlen / 8;

  // Port from the store aligner into the RAM.
  // A read happens whenever en is high, a write only with we.
  typedef struct packed {
    logic                       en;
    logic                       we;
    logic [ram_aw-1:0]          waddr;
    logic [strb_w-1:0]          strb;
    logic [core_pkg::xlen-1:0]  wdata;
  } ram_port_t;

  // One RAM word seen as byte lanes or as halfword lanes.
  // A word lane is halfword 2k+1 over halfword 2k.
  typedef union packed {
    logic [strb_w-1:0][7:0]     b;
    logic [strb_w/2-1:0][15:0]  h;
  } lane_view_u;

endpackage

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

  // Data and address width of the core.
  localparam int unsigned xlen = 64;

  // Compressed instructions supported.
  // Selects halfword instead of word fetch alignment.
  localparam bit has_rvc = 1'b1;

  // Access size.
  // Codes follow the width part of the load/store funct3.
  // Codes 4 to 7 are illegal and always flagged.
  typedef enum logic [2:0] {
    size_byte  = 3'b000,
    size_hword = 3'b001,
    size_word  = 3'b010,
    size_dword = 3'b011
  } size_e;

  // Access kind.
  // A fetch ignores size and is_unsigned.
  typedef enum logic [1:0] {
    kind_load  = 2'b00,
    kind_store = 2'b01,
    kind_fetch = 2'b10
  } kind_e;

  // One request from the core.
  // Every field besides req is valid only while req is high.
  typedef struct packed {
    logic             req;
    kind_e            kind;
    size_e            size;
    logic             is_unsigned;
    logic [xlen-1:0]  addr;
    logic [xlen-1:0]  wdata;
  } mem_req_t;

endpackage

`default_nettype wire
